/* files.f */
common/ao_pkg.sv
verilog/obi_reg_bridge.sv
verilog/soc_ctrl.sv
aon_timer/aon_timer.sv
power_manager/power_manager.sv
verilog/ao_periph_top.sv
tests/tb_ao_periph.sv

/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -j 0
TOP      := tb_ao_periph
FILELIST := files.f

BUILD    := obj_dir
BIN      := $(BUILD)/V$(TOP)
LOG      := sim.log
PASS_MSG := All tests passed
SRCS     := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD) $(LOG)

/* tests/tb_ao_periph.sv */
// ================================================
// Random and directed OBI traffic into the subsystem
// One OBI access in flight at a time
// ================================================
`timescale 1ns/1ps

module tb_ao_periph;

  import ao_pkg::*;

  localparam logic [31:0] BASE_ADDR  = 32'h2000_0000;
  localparam int          MAX_CYCLES = 4000;
  localparam logic [3:0]  SOC        = 4'(SOC_CTRL_IDX);
  localparam logic [3:0]  TMR        = 4'(AON_TIMER_IDX);
  localparam logic [3:0]  PM         = 4'(POWER_MANAGER_IDX);

  logic        clk;
  logic        rst_n;
  logic        req;
  logic [31:0] addr;
  logic        we;
  logic [3:0]  be;
  logic [31:0] wdata;
  logic        gnt;
  logic        rvalid;
  logic [31:0] rdata;
  logic        boot_select;
  logic        core_sleep;
  logic        exit_valid;
  logic [31:0] exit_value;
  logic        timer_irq;
  logic        cpu_powergate;
  logic        cpu_rst_n;

  // Shadow registers and the expected response of the access in flight
  logic        sh_exit_valid;
  logic [31:0] sh_exit_value;
  logic        sh_timer_en;
  logic [31:0] sh_timer_cmp;
  logic        sh_pm_enable;
  logic        exp_check;
  logic [31:0] exp_rdata;
  logic        irq_low_chk;
  int          cycle_cnt = 0;

  ao_periph_top #(
    .BASE_ADDR(BASE_ADDR)
  ) DUT (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .req_i          (req),
    .addr_i         (addr),
    .we_i           (we),
    .be_i           (be),
    .wdata_i        (wdata),
    .gnt_o          (gnt),
    .rvalid_o       (rvalid),
    .rdata_o        (rdata),
    .boot_select_i  (boot_select),
    .core_sleep_i   (core_sleep),
    .exit_valid_o   (exit_valid),
    .exit_value_o   (exit_value),
    .timer_irq_o    (timer_irq),
    .cpu_powergate_o(cpu_powergate),
    .cpu_rst_n_o    (cpu_rst_n)
  );

  initial begin
    clk = 1'b0;
  end

  always #10 clk = ~clk;

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1, "Run stopped at the first error");
  endtask

  task automatic value_error(input string msg);
    fail_run($sformatf("Mismatch at time %0t: %s", $time, msg));
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES) begin
      fail_run($sformatf("Timeout: run did not finish within %0d cycles", MAX_CYCLES));
    end
  end

  function automatic logic [31:0] lane_merge(input logic [31:0] old_v,
                                             input logic [31:0] new_v,
                                             input logic [3:0]  be_m);
    logic [31:0] mask;
    mask = {{8{be_m[3]}}, {8{be_m[2]}}, {8{be_m[1]}}, {8{be_m[0]}}};
    return (old_v & ~mask) | (new_v & mask);
  endfunction

  function automatic logic [31:0] make_addr(input logic [3:0] idx, input logic [5:0] ofs);
    ao_addr_u a;
    a.raw             = BASE_ADDR;
    a.fields.index    = idx;
    a.fields.offset   = ofs;
    a.fields.byte_sel = 2'($urandom);
    return a.raw;
  endfunction

  function automatic logic [31:0] random_reg_addr();
    logic [31:0] res;
    case ($urandom_range(0, 4))
      0:       res = make_addr(SOC, EXIT_VALID_OFS);
      1:       res = make_addr(SOC, EXIT_VALUE_OFS);
      2:       res = make_addr(TMR, TIMER_CTRL_OFS);
      3:       res = make_addr(TMR, TIMER_CMP_OFS);
      default: res = make_addr(PM, PM_ENABLE_OFS);
    endcase
    return res;
  endfunction

  // Bus view of the registers without the live count and state
  function automatic logic [31:0] expected_read(input logic [31:0] addr_r);
    ao_addr_u    a;
    logic [31:0] res;
    a.raw = addr_r;
    res   = UNMAPPED_RDATA;
    if (a.fields.base == BASE_ADDR[31:12]) begin
      if (a.fields.index == SOC) begin
        case (a.fields.offset)
          EXIT_VALID_OFS:  res = {31'h0, sh_exit_valid};
          EXIT_VALUE_OFS:  res = sh_exit_value;
          BOOT_SELECT_OFS: res = {31'h0, boot_select};
          default:         res = UNMAPPED_RDATA;
        endcase
      end else if (a.fields.index == TMR) begin
        case (a.fields.offset)
          TIMER_CTRL_OFS: res = {31'h0, sh_timer_en};
          TIMER_CMP_OFS:  res = sh_timer_cmp;
          default:        res = UNMAPPED_RDATA;
        endcase
      end else if (a.fields.index == PM && a.fields.offset == PM_ENABLE_OFS) begin
        res = {31'h0, sh_pm_enable};
      end
    end
    return res;
  endfunction

  task automatic shadow_write(input logic [31:0] addr_w, input logic [3:0] be_w,
                              input logic [31:0] wdata_w);
    ao_addr_u a;
    a.raw = addr_w;
    if (a.fields.base == BASE_ADDR[31:12]) begin
      if (a.fields.index == SOC && a.fields.offset == EXIT_VALID_OFS && be_w[0]) begin
        sh_exit_valid = wdata_w[0];
      end
      if (a.fields.index == SOC && a.fields.offset == EXIT_VALUE_OFS) begin
        sh_exit_value = lane_merge(sh_exit_value, wdata_w, be_w);
      end
      if (a.fields.index == TMR && a.fields.offset == TIMER_CTRL_OFS && be_w[0]) begin
        sh_timer_en = wdata_w[0];
      end
      if (a.fields.index == TMR && a.fields.offset == TIMER_CMP_OFS) begin
        sh_timer_cmp = lane_merge(sh_timer_cmp, wdata_w, be_w);
      end
      if (a.fields.index == PM && a.fields.offset == PM_ENABLE_OFS && be_w[0]) begin
        sh_pm_enable = wdata_w[0];
      end
    end
  endtask

  // One access held until granted, response taken the next cycle
  task automatic obi_access(input  logic        we_a,
                            input  logic [31:0] addr_a,
                            input  logic [3:0]  be_a,
                            input  logic [31:0] wdata_a,
                            input  logic        chk,
                            input  logic [31:0] exp,
                            output logic [31:0] rd);
    req   = 1'b1;
    we    = we_a;
    addr  = addr_a;
    be    = be_a;
    wdata = wdata_a;
    @(negedge clk);
    while (!gnt) begin
      @(negedge clk);
    end
    exp_check = chk;
    exp_rdata = we_a ? 32'h0 : exp;
    @(posedge clk);
    #1;
    req = 1'b0;
    rd  = 32'h0;
    if (we_a) begin
      shadow_write(addr_a, be_a, wdata_a);
    end else begin
      @(negedge clk);
      rd = rdata;
      @(posedge clk);
      #1;
    end
  endtask

  task automatic write_reg(input logic [31:0] addr_w, input logic [3:0] be_w,
                           input logic [31:0] wdata_w);
    logic [31:0] rd;
    obi_access(1'b1, addr_w, be_w, wdata_w, 1'b1, 32'h0, rd);
  endtask

  task automatic read_expect(input logic [31:0] addr_r, input logic [31:0] exp);
    logic [31:0] rd;
    obi_access(1'b0, addr_r, 4'hf, 32'h0, 1'b1, exp, rd);
  endtask

  task automatic read_value(input logic [31:0] addr_r, output logic [31:0] rd);
    obi_access(1'b0, addr_r, 4'hf, 32'h0, 1'b0, 32'h0, rd);
  endtask

  task automatic wait_cycles_for(input int limit, ref logic sig, input logic level);
    int n;
    n = 0;
    while (sig !== level && n < limit) begin
      @(posedge clk);
      #1;
      n++;
    end
  endtask

  a_rvalid_next: assert property (@(posedge clk) disable iff (!rst_n) gnt |=> rvalid)
    else fail_run("Bus error: grant not followed by rvalid in the next cycle");
  a_no_gnt_pending: assert property (@(posedge clk) disable iff (!rst_n) rvalid |-> !gnt)
    else fail_run("Bus error: grant given while a response was pending");
  a_rdata: assert property (@(posedge clk) disable iff (!rst_n)
    (rvalid && exp_check) |-> rdata == exp_rdata)
    else value_error($sformatf("rdata %h, expected %h", rdata, exp_rdata));
  a_exit_value: assert property (@(posedge clk) disable iff (!rst_n)
    exit_value == sh_exit_value)
    else value_error($sformatf("exit_value %h, expected %h", exit_value, sh_exit_value));
  a_exit_valid: assert property (@(posedge clk) disable iff (!rst_n)
    exit_valid == sh_exit_valid)
    else value_error($sformatf("exit_valid %b, expected %b", exit_valid, sh_exit_valid));
  a_irq_low: assert property (@(posedge clk) disable iff (!rst_n) irq_low_chk |-> !timer_irq)
    else value_error("timer_irq high with compare at all ones");
  a_rst_before_gate: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(cpu_rst_n) |=> $rose(cpu_powergate))
    else fail_run("Power error: gate did not close one cycle after reset");
  a_gate_before_rst: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(cpu_powergate) |=> $rose(cpu_rst_n))
    else fail_run("Power error: reset not released one cycle after the gate opened");
  a_gate_in_reset: assert property (@(posedge clk) disable iff (!rst_n)
    cpu_powergate |-> !cpu_rst_n)
    else fail_run("Power error: gate closed while the CPU reset was released");
  a_sleep_disabled: assert property (@(posedge clk) disable iff (!rst_n)
    (!sh_pm_enable && cpu_rst_n) |=> cpu_rst_n)
    else fail_run("Power error: sleep took effect with the power manager disabled");

  initial begin
    logic [31:0] c1;
    logic [31:0] c2;
    ao_addr_u    bad;
    req           = 1'b0;
    addr          = 32'h0;
    we            = 1'b0;
    be            = 4'h0;
    wdata         = 32'h0;
    boot_select   = 1'b0;
    core_sleep    = 1'b0;
    rst_n         = 1'b0;
    sh_exit_valid = 1'b0;
    sh_exit_value = 32'h0;
    sh_timer_en   = 1'b0;
    sh_timer_cmp  = 32'h0;
    sh_pm_enable  = 1'b0;
    exp_check     = 1'b0;
    exp_rdata     = 32'h0;
    irq_low_chk   = 1'b0;
    void'($urandom(32'hc50a));
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;

    for (int n = 0; n < 150; n++) begin
      case ($urandom_range(0, 5))
        0: write_reg(make_addr(SOC, EXIT_VALUE_OFS), 4'($urandom_range(1, 15)), $urandom);
        1: write_reg(make_addr(TMR, TIMER_CMP_OFS), 4'($urandom_range(1, 15)), $urandom);
        2: write_reg(make_addr(PM, PM_ENABLE_OFS), 4'($urandom_range(1, 15)), $urandom);
        3: write_reg(make_addr(SOC, EXIT_VALID_OFS), 4'($urandom_range(1, 15)), $urandom);
        4: begin
          boot_select = 1'($urandom);
          read_expect(make_addr(SOC, BOOT_SELECT_OFS), {31'h0, boot_select});
        end
        default: begin
          c1 = random_reg_addr();
          read_expect(c1, expected_read(c1));
        end
      endcase
    end

    // Unmapped base, index and offsets
    for (int n = 0; n < 8; n++) begin
      bad.raw         = make_addr(4'($urandom_range(0, 2)), 6'($urandom_range(0, 2)));
      bad.fields.base = bad.fields.base ^ 20'($urandom_range(1, 32'hf_ffff));
      read_expect(bad.raw, UNMAPPED_RDATA);
    end
    for (int idx = 3; idx < 16; idx++) begin
      read_expect(make_addr(4'(idx), 6'($urandom)), UNMAPPED_RDATA);
    end
    for (int n = 0; n < 6; n++) begin
      read_expect(make_addr(SOC, 6'($urandom_range(3, 63))), UNMAPPED_RDATA);
      read_expect(make_addr(TMR, 6'($urandom_range(3, 63))), UNMAPPED_RDATA);
      read_expect(make_addr(PM, 6'($urandom_range(2, 63))), UNMAPPED_RDATA);
    end

    // Timer count, compare hit and compare miss
    write_reg(make_addr(TMR, TIMER_CTRL_OFS), 4'h1, 32'h1);
    read_expect(make_addr(TMR, TIMER_CTRL_OFS), 32'h1);
    read_value(make_addr(TMR, TIMER_COUNT_OFS), c1);
    read_value(make_addr(TMR, TIMER_COUNT_OFS), c2);
    assert (c2 > c1)
      else value_error($sformatf("count %0d then %0d, expected an increase", c1, c2));
    write_reg(make_addr(TMR, TIMER_CMP_OFS), 4'hf, 32'h0);
    wait_cycles_for(10, timer_irq, 1'b1);
    assert (timer_irq) else fail_run("Timer interrupt did not rise with compare at zero");
    write_reg(make_addr(TMR, TIMER_CMP_OFS), 4'hf, 32'hffff_ffff);
    write_reg(make_addr(TMR, TIMER_COUNT_OFS), 4'hf, 32'h0);
    repeat (2) @(posedge clk);
    #1;
    irq_low_chk = 1'b1;
    repeat (30) @(posedge clk);
    #1;
    irq_low_chk = 1'b0;

    // Sleep, gate, wake on the timer compare
    write_reg(make_addr(TMR, TIMER_CTRL_OFS), 4'h1, 32'h0);
    write_reg(make_addr(TMR, TIMER_CMP_OFS), 4'hf, 32'd40);
    write_reg(make_addr(TMR, TIMER_COUNT_OFS), 4'hf, 32'h0);
    write_reg(make_addr(PM, PM_ENABLE_OFS), 4'h1, 32'h1);
    core_sleep = 1'b1;
    wait_cycles_for(10, cpu_powergate, 1'b1);
    assert (cpu_powergate) else fail_run("CPU power gate did not close after sleep request");
    core_sleep = 1'b0;
    read_expect(make_addr(PM, PM_STATE_OFS), {30'h0, GATED});
    write_reg(make_addr(TMR, TIMER_CTRL_OFS), 4'h1, 32'h1);
    wait_cycles_for(100, cpu_rst_n, 1'b1);
    assert (cpu_rst_n) else fail_run("CPU did not wake on the timer interrupt");
    read_expect(make_addr(PM, PM_STATE_OFS), {30'h0, ACTIVE});
    write_reg(make_addr(TMR, TIMER_CTRL_OFS), 4'h1, 32'h0);

    // Sleep request ignored while disabled
    write_reg(make_addr(PM, PM_ENABLE_OFS), 4'h1, 32'h0);
    core_sleep = 1'b1;
    repeat (10) @(posedge clk);
    #1;
    assert (cpu_rst_n && !cpu_powergate) else fail_run("Disabled power manager acted on sleep");
    core_sleep = 1'b0;
    read_expect(make_addr(PM, PM_STATE_OFS), {30'h0, ACTIVE});

    repeat (2) @(posedge clk);
    $display("All tests passed");
    $finish;
  end

endmodule : tb_ao_periph

/* verilog/ao_periph_top.sv */
// ================================================
// Always-on subsystem behind one OBI slave port
// BASE_ADDR must be 4 KiB aligned
// ================================================
`timescale 1ns/1ps

module ao_periph_top #(
  parameter logic [31:0] BASE_ADDR = 32'h2000_0000
) (
  input  logic        clk_i,
  input  logic        rst_n_i,

  input  logic        req_i,
  input  logic [31:0] addr_i,
  input  logic        we_i,
  input  logic [3:0]  be_i,
  input  logic [31:0] wdata_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o,

  input  logic        boot_select_i,
  input  logic        core_sleep_i,
  output logic        exit_valid_o,
  output logic [31:0] exit_value_o,
  output logic        timer_irq_o,
  output logic        cpu_powergate_o,
  output logic        cpu_rst_n_o
);

  import ao_pkg::*;

  logic [NUM_AO_PERIPH-1:0] reg_we;
  logic [NUM_AO_PERIPH-1:0] reg_re;
  logic [5:0]               reg_offset;
  logic [31:0]              reg_wdata;
  logic [3:0]               reg_be;

  logic [31:0] soc_rdata;
  logic [31:0] timer_rdata;
  logic [31:0] pm_rdata;
  logic        timer_irq;

  obi_reg_bridge #(
    .BASE_ADDR(BASE_ADDR)
  ) obi_reg_bridge_i (
    .clk_i,
    .rst_n_i,
    .req_i,
    .addr_i,
    .we_i,
    .be_i,
    .wdata_i,
    .gnt_o,
    .rvalid_o,
    .rdata_o,
    .reg_we_o     (reg_we),
    .reg_re_o     (reg_re),
    .reg_offset_o (reg_offset),
    .reg_wdata_o  (reg_wdata),
    .reg_be_o     (reg_be),
    .soc_rdata_i  (soc_rdata),
    .timer_rdata_i(timer_rdata),
    .pm_rdata_i   (pm_rdata)
  );

  soc_ctrl soc_ctrl_i (
    .clk_i,
    .rst_n_i,
    .we_i         (reg_we[SOC_CTRL_IDX]),
    .re_i         (reg_re[SOC_CTRL_IDX]),
    .offset_i     (reg_offset),
    .wdata_i      (reg_wdata),
    .be_i         (reg_be),
    .boot_select_i,
    .rdata_o      (soc_rdata),
    .exit_valid_o,
    .exit_value_o
  );

  aon_timer aon_timer_i (
    .clk_i,
    .rst_n_i,
    .we_i    (reg_we[AON_TIMER_IDX]),
    .re_i    (reg_re[AON_TIMER_IDX]),
    .offset_i(reg_offset),
    .wdata_i (reg_wdata),
    .be_i    (reg_be),
    .rdata_o (timer_rdata),
    .irq_o   (timer_irq)
  );

  power_manager power_manager_i (
    .clk_i,
    .rst_n_i,
    .we_i           (reg_we[POWER_MANAGER_IDX]),
    .re_i           (reg_re[POWER_MANAGER_IDX]),
    .offset_i       (reg_offset),
    .wdata_i        (reg_wdata),
    .be_i           (reg_be),
    .core_sleep_i,
    .irq_i          (timer_irq),
    .rdata_o        (pm_rdata),
    .cpu_powergate_o,
    .cpu_rst_n_o
  );

  assign timer_irq_o = timer_irq;

endmodule : ao_periph_top

/* power_manager/power_manager.sv */
// ================================================
// CPU domain sleep/wake sequencer
// Wake source is the timer irq only, while gated
// ================================================
`timescale 1ns/1ps

module power_manager (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        we_i,
  input  logic        re_i,
  input  logic [5:0]  offset_i,
  input  logic [31:0] wdata_i,
  input  logic [3:0]  be_i,
  input  logic        core_sleep_i,
  input  logic        irq_i,
  output logic [31:0] rdata_o,
  output logic        cpu_powergate_o,
  output logic        cpu_rst_n_o
);

  import ao_pkg::*;

  pm_state_e   state_q;
  pm_state_e   state_d;
  logic        enable_q;
  logic [31:0] rdata_mux;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ACTIVE: begin
        if (core_sleep_i && enable_q) begin
          state_d = RESET_HOLD;
        end
      end
      // Reset asserted a cycle before the switch opens
      RESET_HOLD: state_d = GATED;
      GATED: begin
        if (irq_i) begin
          state_d = POWER_UP;
        end
      end
      // Power back first, reset released next cycle
      POWER_UP: state_d = ACTIVE;
      default:  state_d = ACTIVE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q  <= ACTIVE;
      enable_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (we_i && offset_i == PM_ENABLE_OFS && be_i[0]) begin
        enable_q <= wdata_i[0];
      end
    end
  end

  assign cpu_rst_n_o     = (state_q == ACTIVE);
  assign cpu_powergate_o = (state_q == GATED);

  always_comb begin
    case (offset_i)
      PM_ENABLE_OFS: rdata_mux = {31'h0, enable_q};
      PM_STATE_OFS:  rdata_mux = {30'h0, state_q};
      default:       rdata_mux = UNMAPPED_RDATA;
    endcase
  end

  assign rdata_o = re_i ? rdata_mux : 32'h0;

  // Gate only ever closes onto a domain already in reset
  a_gate_in_reset: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cpu_powergate_o |-> !cpu_rst_n_o && $past(!cpu_rst_n_o));

endmodule : power_manager

/* aon_timer/aon_timer.sv */
// ================================================
// Always-on 32-bit timer with compare interrupt
// Counter wraps silently, irq is a level
// ================================================
`timescale 1ns/1ps

module aon_timer (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        we_i,
  input  logic        re_i,
  input  logic [5:0]  offset_i,
  input  logic [31:0] wdata_i,
  input  logic [3:0]  be_i,
  output logic [31:0] rdata_o,
  output logic        irq_o
);

  import ao_pkg::*;

  logic        enable_q;
  logic [31:0] count_q;
  logic [31:0] cmp_q;
  logic        irq_q;
  logic [31:0] rdata_mux;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      enable_q <= 1'b0;
      count_q  <= 32'h0;
      cmp_q    <= 32'h0;
      irq_q    <= 1'b0;
    end else begin
      // Software write wins over the increment
      if (we_i && offset_i == TIMER_COUNT_OFS) begin
        count_q <= be_merge(count_q, wdata_i, be_i);
      end else if (enable_q) begin
        count_q <= count_q + 32'd1;
      end

      if (we_i && offset_i == TIMER_CTRL_OFS && be_i[0]) begin
        enable_q <= wdata_i[0];
      end

      if (we_i && offset_i == TIMER_CMP_OFS) begin
        cmp_q <= be_merge(cmp_q, wdata_i, be_i);
      end

      irq_q <= enable_q && (count_q >= cmp_q);
    end
  end

  always_comb begin
    case (offset_i)
      TIMER_CTRL_OFS:  rdata_mux = {31'h0, enable_q};
      TIMER_COUNT_OFS: rdata_mux = count_q;
      TIMER_CMP_OFS:   rdata_mux = cmp_q;
      default:         rdata_mux = UNMAPPED_RDATA;
    endcase
  end

  // Read data only driven during a read strobe
  assign rdata_o = re_i ? rdata_mux : 32'h0;
  assign irq_o   = irq_q;

  a_irq_needs_enable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !enable_q |=> !irq_o);

endmodule : aon_timer

/* verilog/soc_ctrl.sv */
// ================================================
// Exit status and boot-select readback
// Exit value honors byte enables
// ================================================
`timescale 1ns/1ps

module soc_ctrl (
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  logic        we_i,
  input  logic        re_i,
  input  logic [5:0]  offset_i,
  input  logic [31:0] wdata_i,
  input  logic [3:0]  be_i,
  input  logic        boot_select_i,
  output logic [31:0] rdata_o,
  output logic        exit_valid_o,
  output logic [31:0] exit_value_o
);

  import ao_pkg::*;

  logic        exit_valid_q;
  logic [31:0] exit_value_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      exit_valid_q <= 1'b0;
      exit_value_q <= 32'h0;
    end else if (we_i) begin
      if (offset_i == EXIT_VALID_OFS && be_i[0]) begin
        exit_valid_q <= wdata_i[0];
      end
      if (offset_i == EXIT_VALUE_OFS) begin
        exit_value_q <= be_merge(exit_value_q, wdata_i, be_i);
      end
    end
  end

  always_comb begin
    case (offset_i)
      EXIT_VALID_OFS:  rdata_o = {31'h0, exit_valid_q};
      EXIT_VALUE_OFS:  rdata_o = exit_value_q;
      BOOT_SELECT_OFS: rdata_o = {31'h0, boot_select_i};
      default:         rdata_o = UNMAPPED_RDATA;
    endcase
  end

  assign exit_valid_o = exit_valid_q;
  assign exit_value_o = exit_value_q;

  // Bridge strobes one direction per grant
  a_no_we_with_re: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(we_i && re_i));

endmodule : soc_ctrl

/* verilog/obi_reg_bridge.sv */
// ================================================
// OBI slave to register bus, one access in flight
// Response always one cycle after grant, no errors
// ================================================
`timescale 1ns/1ps

module obi_reg_bridge #(
  parameter logic [31:0] BASE_ADDR = 32'h2000_0000
) (
  input  logic        clk_i,
  input  logic        rst_n_i,

  input  logic        req_i,
  input  logic [31:0] addr_i,
  input  logic        we_i,
  input  logic [3:0]  be_i,
  input  logic [31:0] wdata_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o,

  output logic [ao_pkg::NUM_AO_PERIPH-1:0] reg_we_o,
  output logic [ao_pkg::NUM_AO_PERIPH-1:0] reg_re_o,
  output logic [5:0]                       reg_offset_o,
  output logic [31:0]                      reg_wdata_o,
  output logic [3:0]                       reg_be_o,
  input  logic [31:0]                      soc_rdata_i,
  input  logic [31:0]                      timer_rdata_i,
  input  logic [31:0]                      pm_rdata_i
);

  import ao_pkg::*;

  ao_addr_u                 addr;
  logic                     base_hit;
  logic [NUM_AO_PERIPH-1:0] sel;
  logic [31:0]              rdata_sel;
  logic                     pending_q;
  logic [31:0]              rdata_q;

  assign addr.raw = addr_i;
  assign base_hit = (addr.fields.base == BASE_ADDR[31:12]);

  // Grant only when no response is owed
  assign gnt_o = req_i & ~pending_q;

  always_comb begin
    for (int i = 0; i < NUM_AO_PERIPH; i++) begin
      sel[i] = base_hit && (addr.fields.index == 4'(i));
    end
  end

  assign reg_we_o     = sel & {NUM_AO_PERIPH{gnt_o & we_i}};
  assign reg_re_o     = sel & {NUM_AO_PERIPH{gnt_o & ~we_i}};
  assign reg_offset_o = addr.fields.offset;
  assign reg_wdata_o  = wdata_i;
  assign reg_be_o     = be_i;

  always_comb begin
    rdata_sel = UNMAPPED_RDATA;
    if (base_hit) begin
      case (addr.fields.index)
        4'(SOC_CTRL_IDX):      rdata_sel = soc_rdata_i;
        4'(AON_TIMER_IDX):     rdata_sel = timer_rdata_i;
        4'(POWER_MANAGER_IDX): rdata_sel = pm_rdata_i;
        default:               rdata_sel = UNMAPPED_RDATA;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      pending_q <= 1'b0;
    end else begin
      pending_q <= gnt_o;
    end
  end

  // Writes answer with zero data
  always_ff @(posedge clk_i) begin
    if (gnt_o) begin
      rdata_q <= we_i ? 32'h0 : rdata_sel;
    end
  end

  assign rvalid_o = pending_q;
  assign rdata_o  = rdata_q;

  a_one_strobe: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(reg_we_o | reg_re_o));

  a_rvalid_after_gnt: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    gnt_o |=> rvalid_o);

endmodule : obi_reg_bridge

/* common/ao_pkg.sv */
// ================================================
// Register map of the always-on peripherals
// Bits 1:0 of the address are ignored by every register
// ================================================

package ao_pkg;

  // Bus address, whole word or decoded fields
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [19:0] base;
      logic [3:0]  index;
      logic [5:0]  offset;
      logic [1:0]  byte_sel;
    } fields;
  } ao_addr_u;

  // Peripheral slots behind the bridge
  localparam int unsigned SOC_CTRL_IDX      = 0;
  localparam int unsigned AON_TIMER_IDX     = 1;
  localparam int unsigned POWER_MANAGER_IDX = 2;
  localparam int unsigned NUM_AO_PERIPH     = 3;

  // SoC control
  localparam logic [5:0] EXIT_VALID_OFS  = 6'd0;
  localparam logic [5:0] EXIT_VALUE_OFS  = 6'd1;
  localparam logic [5:0] BOOT_SELECT_OFS = 6'd2;

  // Timer
  localparam logic [5:0] TIMER_CTRL_OFS  = 6'd0;
  localparam logic [5:0] TIMER_COUNT_OFS = 6'd1;
  localparam logic [5:0] TIMER_CMP_OFS   = 6'd2;

  // Power manager
  localparam logic [5:0] PM_ENABLE_OFS = 6'd0;
  localparam logic [5:0] PM_STATE_OFS  = 6'd1;

  localparam logic [31:0] UNMAPPED_RDATA = 32'hdead_beef;

  typedef enum logic [1:0] {
    ACTIVE     = 2'd0,
    RESET_HOLD = 2'd1,
    GATED      = 2'd2,
    POWER_UP   = 2'd3
  } pm_state_e;

  // Byte lane merge for partial writes
  function automatic logic [31:0] be_merge(input logic [31:0] old_val,
                                           input logic [31:0] new_val,
                                           input logic [3:0]  be);
    logic [31:0] res;
    res = old_val;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return res;
  endfunction

endpackage : ao_pkg
